// File: design/panel_params.svh
// Panel geometry and command opcodes

`ifndef PANEL_PARAMS_SVH
`define PANEL_PARAMS_SVH

// Panel size in pixels
`define PANEL_COLS 512
`define PANEL_ROWS 16

// Bytes stored per pixel (blue, green, red)
`define BYTES_PER_PIXEL 3

// A column value arrives as this many bytes, high byte first
`define COL_FIELD_BYTES 2

`define OP_FILLRECT 8'h01

`endif

// File: design/panel_pkg.sv
// Panel controller types

`default_nettype none

package panel_pkg;

`include "panel_params.svh"

    // Addresses inside the framebuffer
    typedef logic [$clog2(`PANEL_COLS)-1:0] col_addr_t;
    typedef logic [$clog2(`PANEL_ROWS)-1:0] row_addr_t;
    typedef logic [$clog2(`BYTES_PER_PIXEL)-1:0] pixel_index_t;

    // Command fields as received, may exceed the panel
    typedef logic [8*`COL_FIELD_BYTES-1:0] col_field_t;
    typedef logic [7:0] row_field_t;

    typedef struct packed {
        logic [7:0] blue;
        logic [7:0] green;
        logic [7:0] red;
    } color_t;

    typedef struct packed {
        row_addr_t    row;
        col_addr_t    col;
        pixel_index_t pixel;
    } fb_addr_t;

endpackage

`default_nettype wire

// File: design/fb_write_if.sv
// Framebuffer byte write bus

`timescale 1ns/1ps
`default_nettype none

interface fb_write_if import panel_pkg::*; ();
    row_addr_t    row;
    col_addr_t    col;
    pixel_index_t pixel;
    logic [7:0]   data;
    logic         write_enable; // One byte per strobe

    modport source (output row, col, pixel, data, write_enable);
    modport sink   (input row, col, pixel, data, write_enable);
endinterface

`default_nettype wire

// File: design/cmd_dispatch.sv
// Command opcode dispatcher

`timescale 1ns/1ps
`default_nettype none

`include "panel_params.svh"

module cmd_dispatch (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] data_in,
    input  wire logic       data_valid,
    output logic            ready_for_data,
    output logic            fill_valid,
    output logic [7:0]      fill_data,
    input  wire logic       fill_busy,
    input  wire logic       fill_done
);
    typedef enum logic {
        S_OPCODE,
        S_PAYLOAD
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_OPCODE;
        end else begin
            case (state)
                S_OPCODE: begin
                    // Other opcodes are consumed and dropped
                    if (data_valid && data_in == `OP_FILLRECT) begin
                        state <= S_PAYLOAD;
                    end
                end
                S_PAYLOAD: begin
                    if (fill_done) begin
                        state <= S_OPCODE;
                    end
                end
                default: state <= S_OPCODE;
            endcase
        end
    end

    assign ready_for_data = ~fill_busy;

    // Payload bytes only, nothing while the draw runs
    assign fill_valid = data_valid && (state == S_PAYLOAD) && !fill_busy;
    assign fill_data  = data_in;

endmodule

`default_nettype wire

// File: design/fill_area_walker.sv
// Clipped rectangle walker

`timescale 1ns/1ps
`default_nettype none

`include "panel_params.svh"

module fill_area_walker import panel_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       start,
    input  wire col_field_t x1,
    input  wire col_field_t width,
    input  wire row_field_t y1,
    input  wire row_field_t height,
    input  wire color_t     color,
    output logic            finished,
    fb_write_if.source      fb
);
    col_addr_t    start_col, end_col, col;
    row_addr_t    end_row, row;
    pixel_index_t pixel;
    logic         active;
    logic         empty_done;
    logic         last_byte;
    logic [16:0]  last_col_wide;
    logic [8:0]   last_row_wide;
    logic         off_panel;

    always_comb begin
        last_col_wide = {1'b0, x1} + {1'b0, width} - 17'd1;
        last_row_wide = {1'b0, y1} + {1'b0, height} - 9'd1;
        off_panel = (width == '0) || (height == '0) ||
                    (x1 >= 16'(`PANEL_COLS)) || (y1 >= 8'(`PANEL_ROWS));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active     <= 1'b0;
            empty_done <= 1'b0;
        end else begin
            empty_done <= start && off_panel; // Nothing to write
            if (start && !off_panel) active <= 1'b1;
            else if (last_byte) active <= 1'b0;
        end
    end

    // Counters and clipped bounds
    always_ff @(posedge clk) begin
        if (start) begin
            start_col <= col_addr_t'(x1);
            col       <= col_addr_t'(x1);
            row       <= row_addr_t'(y1);
            pixel     <= '0;
            end_col   <= (last_col_wide >= 17'(`PANEL_COLS)) ?
                         col_addr_t'(`PANEL_COLS - 1) : col_addr_t'(last_col_wide);
            end_row   <= (last_row_wide >= 9'(`PANEL_ROWS)) ?
                         row_addr_t'(`PANEL_ROWS - 1) : row_addr_t'(last_row_wide);
        end else if (active) begin
            if (pixel == pixel_index_t'(`BYTES_PER_PIXEL - 1)) begin
                pixel <= '0;
                if (col == end_col) begin
                    col <= start_col;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end else begin
                pixel <= pixel + 1'b1;
            end
        end
    end

    assign last_byte = active && (pixel == pixel_index_t'(`BYTES_PER_PIXEL - 1)) &&
                       (col == end_col) && (row == end_row);
    assign finished = last_byte || empty_done;

    assign fb.row          = row;
    assign fb.col          = col;
    assign fb.pixel        = pixel;
    assign fb.write_enable = active;
    assign fb.data = (pixel == 2'd0) ? color.blue :
                     (pixel == 2'd1) ? color.green : color.red;

endmodule

`default_nettype wire

// File: design/cmd_fillrect.sv
// Fill-rectangle command

`timescale 1ns/1ps
`default_nettype none

`include "panel_params.svh"

module cmd_fillrect import panel_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       byte_valid,
    input  wire logic [7:0] byte_data,
    output logic            busy,
    output logic            done,
    fb_write_if.source      fb
);
    typedef enum logic [2:0] {
        S_X1,
        S_Y1,
        S_WIDTH,
        S_HEIGHT,
        S_COLOR,
        S_START,
        S_RUN,
        S_DONE
    } state_t;

    localparam int FIELD_IDX_W = $clog2(`COL_FIELD_BYTES);

    state_t                 state;
    logic [FIELD_IDX_W-1:0] x1_cnt;
    logic [FIELD_IDX_W-1:0] width_cnt;
    pixel_index_t           color_cnt;
    col_field_t             x1;
    col_field_t             width;
    row_field_t             y1;
    row_field_t             height;
    color_t                 color;
    logic                   walker_finished;

    always_ff @(posedge clk) begin
        if (reset || state == S_DONE) begin
            state     <= S_X1;
            x1_cnt    <= FIELD_IDX_W'(`COL_FIELD_BYTES - 1);
            width_cnt <= FIELD_IDX_W'(`COL_FIELD_BYTES - 1);
            color_cnt <= pixel_index_t'(`BYTES_PER_PIXEL - 1);
            x1        <= '0;
            width     <= '0;
            y1        <= '0;
            height    <= '0;
            color     <= '0;
        end else begin
            case (state)
                S_X1: if (byte_valid) begin
                    x1[x1_cnt*8 +: 8] <= byte_data; // High byte first
                    if (x1_cnt == '0) state <= S_Y1;
                    else x1_cnt <= x1_cnt - 1'b1;
                end
                S_Y1: if (byte_valid) begin
                    y1    <= byte_data;
                    state <= S_WIDTH;
                end
                S_WIDTH: if (byte_valid) begin
                    width[width_cnt*8 +: 8] <= byte_data;
                    if (width_cnt == '0) state <= S_HEIGHT;
                    else width_cnt <= width_cnt - 1'b1;
                end
                S_HEIGHT: if (byte_valid) begin
                    height <= byte_data;
                    state  <= S_COLOR;
                end
                S_COLOR: if (byte_valid) begin
                    case (color_cnt) // Sent as blue, green, red
                        2'd2:    color.blue  <= byte_data;
                        2'd1:    color.green <= byte_data;
                        default: color.red   <= byte_data;
                    endcase
                    if (color_cnt == '0) state <= S_START;
                    else color_cnt <= color_cnt - 1'b1;
                end
                S_START: state <= S_RUN;
                S_RUN: if (walker_finished) state <= S_DONE;
                default: state <= S_X1;
            endcase
        end
    end

    assign busy = (state == S_START) || (state == S_RUN) || (state == S_DONE);
    assign done = (state == S_DONE);

    fill_area_walker u_walker (
        .clk      (clk),
        .reset    (reset),
        .start    (state == S_START),
        .x1       (x1),
        .width    (width),
        .y1       (y1),
        .height   (height),
        .color    (color),
        .finished (walker_finished),
        .fb       (fb)
    );

endmodule

`default_nettype wire

// File: design/framebuffer.sv
// Panel framebuffer

`timescale 1ns/1ps
`default_nettype none

`include "panel_params.svh"

module framebuffer import panel_pkg::*; (
    input  wire logic     clk,
    fb_write_if.sink      wr,
    input  wire fb_addr_t rd_addr,
    output logic [7:0]    rd_data
);
    localparam int FB_BYTES = `PANEL_ROWS * `PANEL_COLS * `BYTES_PER_PIXEL;

    logic [7:0] mem [FB_BYTES];

    // Row-major, pixel bytes adjacent
    function automatic int unsigned byte_index(
        input row_addr_t    r,
        input col_addr_t    c,
        input pixel_index_t p
    );
        return (int'(r) * `PANEL_COLS + int'(c)) * `BYTES_PER_PIXEL + int'(p);
    endfunction

    always_ff @(posedge clk) begin
        if (wr.write_enable) begin
            mem[byte_index(wr.row, wr.col, wr.pixel)] <= wr.data;
        end
        rd_data <= mem[byte_index(rd_addr.row, rd_addr.col, rd_addr.pixel)];
    end

endmodule

`default_nettype wire

// File: design/panel_ctrl_top.sv
// LED panel command controller

`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_top import panel_pkg::*; (
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire logic [7:0]   data_in,
    input  wire logic         data_valid,
    output logic              ready_for_data,
    output logic              done,
    input  wire row_addr_t    rd_row,
    input  wire col_addr_t    rd_col,
    input  wire pixel_index_t rd_pixel,
    output logic [7:0]        rd_data
);
    logic       fill_valid;
    logic [7:0] fill_data;
    logic       fill_busy;
    fb_addr_t   rd_addr;

    fb_write_if fb_bus ();

    assign rd_addr = '{row: rd_row, col: rd_col, pixel: rd_pixel};

    cmd_dispatch u_dispatch (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .data_valid     (data_valid),
        .ready_for_data (ready_for_data),
        .fill_valid     (fill_valid),
        .fill_data      (fill_data),
        .fill_busy      (fill_busy),
        .fill_done      (done)
    );

    cmd_fillrect u_fillrect (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (fill_valid),
        .byte_data  (fill_data),
        .busy       (fill_busy),
        .done       (done),
        .fb         (fb_bus.source)
    );

    framebuffer u_framebuffer (
        .clk     (clk),
        .wr      (fb_bus.sink),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: bench/panel_ctrl_asserts.sv
// Controller protocol assertions

`timescale 1ns/1ps
`default_nettype none

`include "panel_params.svh"

module panel_ctrl_asserts import panel_pkg::*; (
    input wire logic         clk,
    input wire logic         reset,
    input wire logic         done,
    input wire logic         ready_for_data,
    input wire logic         write_enable,
    input wire pixel_index_t wr_pixel
);
    int unsigned failures = 0;

    done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failures++;
        end

    // Writes only while a draw holds the input off
    write_while_busy: assert property (@(posedge clk) disable iff (reset)
        write_enable |-> !ready_for_data)
        else begin
            $error("framebuffer write while ready_for_data was high");
            failures++;
        end

    // Row and column types cover exactly the panel, the byte index does not
    write_in_panel: assert property (@(posedge clk) disable iff (reset)
        write_enable |-> (int'(wr_pixel) < `BYTES_PER_PIXEL))
        else begin
            $error("framebuffer write address outside the panel");
            failures++;
        end

    ready_around_done: assert property (@(posedge clk) disable iff (reset)
        done |-> !ready_for_data ##1 ready_for_data)
        else begin
            $error("ready_for_data not low with done and high the cycle after");
            failures++;
        end

endmodule

bind panel_ctrl_top panel_ctrl_asserts u_asserts (
    .clk            (clk),
    .reset          (reset),
    .done           (done),
    .ready_for_data (ready_for_data),
    .write_enable   (fb_bus.write_enable),
    .wr_pixel       (fb_bus.pixel)
);

`default_nettype wire

// File: bench/panel_ctrl_tb.sv
// Panel controller testbench

`timescale 1ns/1ps
`default_nettype none

`include "panel_params.svh"

module panel_ctrl_tb import panel_pkg::*; ();
    localparam int FB_BYTES = `PANEL_ROWS * `PANEL_COLS * `BYTES_PER_PIXEL;
    localparam int DONE_TIMEOUT = FB_BYTES + 100; // Longest draw plus margin
    localparam int MAX_ERROR_LINES = 20;

    logic         clk;
    logic         reset;
    logic [7:0]   data_in;
    logic         data_valid;
    logic         ready_for_data;
    logic         done;
    row_addr_t    rd_row;
    col_addr_t    rd_col;
    pixel_index_t rd_pixel;
    logic [7:0]   rd_data;

    logic [7:0]  model [FB_BYTES]; // Expected framebuffer contents
    logic [31:0] rng_state = 32'hcc4f_b7e7;
    int unsigned errors = 0;

    panel_ctrl_top UUT (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .data_valid     (data_valid),
        .ready_for_data (ready_for_data),
        .done           (done),
        .rd_row         (rd_row),
        .rd_col         (rd_col),
        .rd_pixel       (rd_pixel),
        .rd_data        (rd_data)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic color_t random_color();
        logic [31:0] r;
        r = next_random();
        return color_t'(r[23:0]);
    endfunction

    // Row-major, three bytes per pixel
    function automatic int model_index(input int r, input int c, input int p);
        return (r * `PANEL_COLS + c) * `BYTES_PER_PIXEL + p;
    endfunction

    task automatic send_byte(input logic [7:0] value);
        @(posedge clk);
        #1;
        data_in    = value;
        data_valid = 1'b1;
        @(posedge clk);
        #1;
        data_valid = 1'b0;
    endtask

    // Junk strobes only go out while ready_for_data is low
    task automatic wait_done(input bit send_junk);
        int          cycles;
        bit          seen;
        logic [31:0] r;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (done) begin
                seen       = 1'b1;
                data_valid = 1'b0;
            end else if (send_junk && !ready_for_data) begin
                r          = next_random();
                data_in    = r[7:0];
                data_valid = r[8];
            end
        end
        if (!seen) begin
            errors++;
            data_valid = 1'b0;
            $display("Timeout: done did not arrive within %0d cycles", DONE_TIMEOUT);
        end
    endtask

    task automatic apply_model(input int x1, input int y1, input int width, input int height,
                               input color_t color);
        for (int r = y1; r < y1 + height && r < `PANEL_ROWS; r++) begin
            for (int c = x1; c < x1 + width && c < `PANEL_COLS; c++) begin
                model[model_index(r, c, 0)] = color.blue;
                model[model_index(r, c, 1)] = color.green;
                model[model_index(r, c, 2)] = color.red;
            end
        end
    endtask

    task automatic verify_panel();
        int idx;
        for (int r = 0; r < `PANEL_ROWS; r++) begin
            for (int c = 0; c < `PANEL_COLS; c++) begin
                for (int p = 0; p < `BYTES_PER_PIXEL; p++) begin
                    @(posedge clk);
                    #1;
                    rd_row   = row_addr_t'(r);
                    rd_col   = col_addr_t'(c);
                    rd_pixel = pixel_index_t'(p);
                    @(posedge clk);
                    #1; // One cycle read latency
                    idx = model_index(r, c, p);
                    if (rd_data !== model[idx]) begin
                        errors++;
                        if (errors <= MAX_ERROR_LINES) begin
                            $display("ERROR rd_data row %0d col %0d pixel %0d: expected %h, got %h",
                                     r, c, p, model[idx], rd_data);
                        end
                    end
                end
            end
        end
    endtask

    task automatic fill_rect(input int x1, input int y1, input int width, input int height,
                             input color_t color, input bit send_junk);
        send_byte(`OP_FILLRECT);
        send_byte(x1[15:8]);
        send_byte(x1[7:0]);
        send_byte(y1[7:0]);
        send_byte(width[15:8]);
        send_byte(width[7:0]);
        send_byte(height[7:0]);
        send_byte(color.blue);
        send_byte(color.green);
        send_byte(color.red);
        wait_done(send_junk);
        apply_model(x1, y1, width, height, color);
        verify_panel();
    endtask

    initial begin
        logic [31:0] r;
        int          x1;
        int          y1;
        int          w;
        int          h;
        clk        = 1'b0;
        reset      = 1'b1;
        data_in    = 8'h00;
        data_valid = 1'b0;
        rd_row     = '0;
        rd_col     = '0;
        rd_pixel   = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        if (ready_for_data !== 1'b1) begin
            errors++;
            $display("ERROR ready_for_data after reset: expected 1, got %h", ready_for_data);
        end
        if (done !== 1'b0) begin
            errors++;
            $display("ERROR done after reset: expected 0, got %h", done);
        end

        fill_rect(0, 0, `PANEL_COLS, `PANEL_ROWS, random_color(), 1'b0); // Whole panel

        // Overlapping pair, then random ones
        fill_rect(100, 2, 64, 6, random_color(), 1'b0);
        fill_rect(130, 5, 64, 8, random_color(), 1'b0);
        repeat (4) begin
            x1 = int'(next_random() % 32'd600);
            y1 = int'(next_random() % 32'd20);
            w  = int'(next_random() % 32'd200);
            h  = int'(next_random() % 32'd18);
            fill_rect(x1, y1, w, h, random_color(), 1'b0);
        end

        fill_rect(480, 12, 64, 8, random_color(), 1'b0);   // Clipped at both edges
        fill_rect(600, 3, 10, 4, random_color(), 1'b0);
        fill_rect(10, 40, 10, 4, random_color(), 1'b0);

        fill_rect(50, 4, 0, 3, random_color(), 1'b0);      // Empty rectangles
        fill_rect(50, 4, 10, 0, random_color(), 1'b0);

        send_byte(8'h00);
        send_byte(8'h02);
        send_byte(8'hff);
        r = next_random();
        send_byte((r[7:0] == `OP_FILLRECT) ? 8'h80 : r[7:0]);
        fill_rect(300, 1, 20, 5, random_color(), 1'b0);

        // Dropped strobes during a long draw
        fill_rect(0, 0, 256, 16, random_color(), 1'b1);
        fill_rect(250, 6, 30, 3, random_color(), 1'b0);

        $display("Errors: %0d, assertion failures: %0d",
                 errors, UUT.u_asserts.failures);
        if (errors == 0 && UUT.u_asserts.failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/panel_pkg.sv
design/fb_write_if.sv
design/cmd_dispatch.sv
design/fill_area_walker.sv
design/cmd_fillrect.sv
design/framebuffer.sv
design/panel_ctrl_top.sv
bench/panel_ctrl_asserts.sv
bench/panel_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the panel controller

BUILD := build

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module panel_ctrl_tb -f sources.f -Mdir $(BUILD)
	./$(BUILD)/Vpanel_ctrl_tb > $(BUILD)/sim.log 2>&1 || true
	@cat $(BUILD)/sim.log
	@if grep -q "Something failed" $(BUILD)/sim.log; then echo "test: failure in log"; exit 1; fi
	@grep -q "Everything OK" $(BUILD)/sim.log || (echo "test: run did not complete"; exit 1)

clean:
	rm -rf $(BUILD)
